// File: oflow_cfg.svh
`ifndef OFLOW_CFG_SVH
`define OFLOW_CFG_SVH

// ----------------------------------------
// box geometry
// ----------------------------------------
`define COORD_W       10                 // pixel coordinate bits
`define AREA_W        (2*`COORD_W)       // width times height

// ----------------------------------------
// cost format, unsigned q0.16
// ----------------------------------------
`define FRAC_W        16
`define COST_W        `FRAC_W
`define QUOT_W        (`FRAC_W+1)        // extra bit, quotient hits 1.0 on identical boxes

// ----------------------------------------
// history table
// ----------------------------------------
`define HIST_DEPTH    4                  // slots walked per run
`define SLOT_W        2                  // log2 of HIST_DEPTH

// costs strictly above this are reported as no match
`define NO_MATCH_THR  16'hE000

`endif

// File: oflow_bbox_pkg.sv
`include "oflow_cfg.svh"

// box and cost types shared by the datapath blocks
package oflow_bbox_pkg;

	// ----------------------------------------
	// geometry
	// ----------------------------------------
	typedef logic [`COORD_W-1:0] coord_t;  // one corner coordinate
	typedef logic [`AREA_W-1:0]  area_t;   // w*h, also the intersection

	// ----------------------------------------
	// scoring
	// ----------------------------------------
	typedef logic [`COST_W-1:0]  cost_t;   // 1 - iou, all ones = worst
	typedef logic [`SLOT_W-1:0]  slot_t;   // history slot number

endpackage

// File: oflow_ctrl_pkg.sv
// controller encodings, kept apart from the box types
package oflow_ctrl_pkg;

	// ----------------------------------------
	// match controller states
	// ----------------------------------------
	typedef enum logic [2:0] {
		idle_st,     // waiting for start
		fetch_st,    // slot addressed, kick the iou block
		score_st,    // waiting on iou_valid
		compare_st,  // step to next slot or wrap up
		finish_st    // results final, done goes out
	} match_state_t;

endpackage

// File: oflow_history_buf.sv
`include "oflow_cfg.svh"

module oflow_history_buf (
	input  logic                   clk,
	input  logic                   reset_N,
	input  logic                   we,
	input  oflow_bbox_pkg::slot_t  waddr,
	input  oflow_bbox_pkg::coord_t w_x_tl,
	input  oflow_bbox_pkg::coord_t w_y_tl,
	input  oflow_bbox_pkg::coord_t w_x_br,
	input  oflow_bbox_pkg::coord_t w_y_br,
	input  oflow_bbox_pkg::slot_t  raddr,
	output oflow_bbox_pkg::coord_t r_x_tl,
	output oflow_bbox_pkg::coord_t r_y_tl,
	output oflow_bbox_pkg::coord_t r_x_br,
	output oflow_bbox_pkg::coord_t r_y_br
);
	import oflow_bbox_pkg::*;

	// one register column per coordinate
	coord_t x_tl_q [`HIST_DEPTH];
	coord_t y_tl_q [`HIST_DEPTH];
	coord_t x_br_q [`HIST_DEPTH];
	coord_t y_br_q [`HIST_DEPTH];

	// ----------------------------------------
	// host write, one box per cycle
	// ----------------------------------------
	always_ff @(posedge clk or posedge reset_N) begin
		if (reset_N) begin
			for (int i = 0; i < `HIST_DEPTH; i++) begin
				x_tl_q[i] <= '0;  // empty boxes after reset
				y_tl_q[i] <= '0;
				x_br_q[i] <= '0;
				y_br_q[i] <= '0;
			end
		end else if (we) begin
			x_tl_q[waddr] <= w_x_tl;
			y_tl_q[waddr] <= w_y_tl;
			x_br_q[waddr] <= w_x_br;
			y_br_q[waddr] <= w_y_br;
		end
	end

	// ----------------------------------------
	// read side, follows the slot counter
	// ----------------------------------------
	assign r_x_tl = x_tl_q[raddr];
	assign r_y_tl = y_tl_q[raddr];
	assign r_x_br = x_br_q[raddr];
	assign r_y_br = y_br_q[raddr];

endmodule

// File: oflow_seq_div.sv
`include "oflow_cfg.svh"

// restoring divider, one quotient bit per clock, QUOT_W bits total
// caller guarantees num >> QUOT_W < den, so only the low QUOT_W bits are produced
module oflow_seq_div #(
	parameter int NUM_W = 36,
	parameter int DEN_W = 21
) (
	input  logic               clk,
	input  logic               reset_N,
	input  logic               start,
	input  logic [NUM_W-1:0]   num,
	input  logic [DEN_W-1:0]   den,
	output logic               complete,
	output logic               busy,
	output logic [`QUOT_W-1:0] quotient
);
	localparam int CNT_W = $clog2(`QUOT_W);

	logic [DEN_W-1:0]   rem_q;    // partial remainder
	logic [DEN_W-1:0]   rem_cur;
	logic [DEN_W-1:0]   rem_nxt;
	logic [`QUOT_W-1:0] qr_q;     // dividend bits out the top, quotient bits in the bottom
	logic [`QUOT_W-1:0] qr_cur;
	logic [`QUOT_W-1:0] qr_nxt;
	logic [DEN_W-1:0]   den_q;
	logic [DEN_W-1:0]   den_cur;
	logic [DEN_W:0]     trial;
	logic               take;
	logic [CNT_W-1:0]   cnt_q;    // bits still to go

	// ----------------------------------------
	// one restoring step
	// ----------------------------------------
	always_comb begin
		// first bit is taken straight off the inputs on the start edge
		rem_cur = start ? DEN_W'(num[NUM_W-1:`QUOT_W]) : rem_q;
		qr_cur  = start ? num[`QUOT_W-1:0] : qr_q;
		den_cur = start ? den : den_q;
		trial   = {rem_cur, qr_cur[`QUOT_W-1]};           // shift next dividend bit in
		take    = (trial >= {1'b0, den_cur});
		rem_nxt = take ? DEN_W'(trial - {1'b0, den_cur}) : trial[DEN_W-1:0];
		qr_nxt  = {qr_cur[`QUOT_W-2:0], take};
	end

	always_ff @(posedge clk) begin
		if (start || busy) begin
			rem_q <= rem_nxt;
			qr_q  <= qr_nxt;
		end
		if (start)
			den_q <= den;  // held for the whole operation
	end

	// ----------------------------------------
	// sequencing
	// ----------------------------------------
	always_ff @(posedge clk or posedge reset_N) begin
		if (reset_N) begin
			busy     <= 1'b0;
			complete <= 1'b0;
			cnt_q    <= '0;
		end else begin
			complete <= 1'b0;  // single pulse
			if (start) begin
				busy  <= 1'b1;
				cnt_q <= CNT_W'(`QUOT_W - 1);
			end else if (busy) begin
				cnt_q <= cnt_q - 1'b1;
				if (cnt_q == CNT_W'(1)) begin
					busy     <= 1'b0;  // last bit lands this edge
					complete <= 1'b1;
				end
			end
		end
	end

	assign quotient = qr_q;

	// one operation at a time, upstream has to wait for complete
	a_no_start_busy: assert property (@(posedge clk) disable iff (reset_N)
		start |-> !busy);

	// zero union is steered around the divider by the iou block
	a_den_nonzero: assert property (@(posedge clk) disable iff (reset_N)
		start |-> (den != '0));

endmodule

// File: oflow_calc_iou.sv
`include "oflow_cfg.svh"

module oflow_calc_iou (
	input  logic                   clk,
	input  logic                   reset_N,
	input  logic                   start,
	input  oflow_bbox_pkg::coord_t a_x_tl,   // current box
	input  oflow_bbox_pkg::coord_t a_y_tl,
	input  oflow_bbox_pkg::coord_t a_x_br,
	input  oflow_bbox_pkg::coord_t a_y_br,
	input  oflow_bbox_pkg::coord_t b_x_tl,   // history slot
	input  oflow_bbox_pkg::coord_t b_y_tl,
	input  oflow_bbox_pkg::coord_t b_x_br,
	input  oflow_bbox_pkg::coord_t b_y_br,
	output logic                   valid_iou,
	output oflow_bbox_pkg::cost_t  iou_cost
);
	import oflow_bbox_pkg::*;

	localparam int UNION_W = `AREA_W + 1;        // a + b can carry one bit
	localparam int NUM_W   = `AREA_W + `FRAC_W;

	// stage 1
	logic   s1_v;
	coord_t i_x_tl_q;
	coord_t i_y_tl_q;
	coord_t i_x_br_q;
	coord_t i_y_br_q;
	coord_t a_w_q;
	coord_t a_h_q;
	coord_t b_w_q;
	coord_t b_h_q;
	coord_t i_w;
	coord_t i_h;
	// stage 2
	logic   s2_v;
	area_t  inter_q;
	area_t  area_a_q;
	area_t  area_b_q;
	// stage 3 and divider
	logic [UNION_W-1:0] union_c;
	logic [UNION_W-1:0] union_q;
	logic [UNION_W-1:0] div_den;
	logic [NUM_W-1:0]   div_num;
	logic               div_complete;
	logic               div_busy;
	logic [`QUOT_W-1:0] quot;

	function automatic coord_t cmax(input coord_t x, input coord_t y);
		return (x > y) ? x : y;
	endfunction

	function automatic coord_t cmin(input coord_t x, input coord_t y);
		return (x < y) ? x : y;
	endfunction

	// extent of one axis, zero unless br is strictly past tl
	function automatic coord_t span(input coord_t tl, input coord_t br);
		return (br > tl) ? coord_t'(br - tl) : '0;
	endfunction

	// ----------------------------------------
	// stage 1: corners and sides
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (start) begin
			i_x_tl_q <= cmax(a_x_tl, b_x_tl);  // inner top-left
			i_y_tl_q <= cmax(a_y_tl, b_y_tl);
			i_x_br_q <= cmin(a_x_br, b_x_br);  // inner bottom-right
			i_y_br_q <= cmin(a_y_br, b_y_br);
			a_w_q    <= span(a_x_tl, a_x_br);
			a_h_q    <= span(a_y_tl, a_y_br);
			b_w_q    <= span(b_x_tl, b_x_br);
			b_h_q    <= span(b_y_tl, b_y_br);
		end
	end

	assign i_w = span(i_x_tl_q, i_x_br_q);  // empty overlap folds to 0
	assign i_h = span(i_y_tl_q, i_y_br_q);

	// ----------------------------------------
	// stage 2: areas
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (s1_v) begin
			inter_q  <= area_t'(i_w) * area_t'(i_h);
			area_a_q <= area_t'(a_w_q) * area_t'(a_h_q);
			area_b_q <= area_t'(b_w_q) * area_t'(b_h_q);
		end
	end

	// ----------------------------------------
	// stage 3: union, divider kick
	// ----------------------------------------
	// overlap lies inside both boxes, so no underflow
	assign union_c = UNION_W'(area_a_q) + UNION_W'(area_b_q) - UNION_W'(inter_q);
	assign div_num = {inter_q, {`FRAC_W{1'b0}}};                 // inter << FRAC_W
	assign div_den = (union_c == '0) ? UNION_W'(1) : union_c;   // dummy den, latency stays fixed

	always_ff @(posedge clk) begin
		if (s2_v)
			union_q <= union_c;
	end

	oflow_seq_div #(
		.NUM_W (NUM_W),
		.DEN_W (UNION_W)
	) div_i (
		.clk      (clk),
		.reset_N  (reset_N),
		.start    (s2_v),
		.num      (div_num),
		.den      (div_den),
		.complete (div_complete),
		.busy     (div_busy),
		.quotient (quot)
	);

	// ----------------------------------------
	// cost = all ones - q, floored at 0
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (div_complete) begin
			if (union_q == '0)
				iou_cost <= '1;                      // nothing to compare against
			else if (quot[`QUOT_W-1])
				iou_cost <= '0;                      // q == 1.0, same box
			else
				iou_cost <= ~quot[`COST_W-1:0];      // ffff - q
		end
	end

	always_ff @(posedge clk or posedge reset_N) begin
		if (reset_N) begin
			s1_v      <= 1'b0;
			s2_v      <= 1'b0;
			valid_iou <= 1'b0;
		end else begin
			s1_v      <= start;
			s2_v      <= s1_v;
			valid_iou <= div_complete;  // cost lands with it
		end
	end

	// front end and divider carry a single box pair end to end
	a_one_in_flight: assert property (@(posedge clk) disable iff (reset_N)
		start |-> !(s1_v || s2_v || div_busy || div_complete || valid_iou));

endmodule

// File: oflow_slot_counter.sv
`include "oflow_cfg.svh"

module oflow_slot_counter (
	input  logic                  clk,
	input  logic                  reset_N,
	input  logic                  clr,
	input  logic                  step,
	output oflow_bbox_pkg::slot_t slot_idx,
	output logic                  slot_last
);

	// ----------------------------------------
	// slot index
	// ----------------------------------------
	always_ff @(posedge clk or posedge reset_N) begin
		if (reset_N) begin
			slot_idx <= '0;
		end else if (clr) begin
			slot_idx <= '0;             // new run from slot 0
		end else if (step) begin
			slot_idx <= slot_idx + 1'b1;
		end
	end

	// last slot of the table
	assign slot_last = (slot_idx == (`HIST_DEPTH - 1));

endmodule

// File: oflow_match_fsm.sv
module oflow_match_fsm (
	input  logic clk,
	input  logic reset_N,
	input  logic start,
	input  logic iou_valid,
	input  logic slot_last,
	output logic iou_start,
	output logic cnt_clr,
	output logic cnt_step,
	output logic sel_clr,
	output logic sel_load,
	output logic done,
	output logic busy
);
	import oflow_ctrl_pkg::*;

	match_state_t state;
	match_state_t next_state;

	// ----------------------------------------
	// state register
	// ----------------------------------------
	always_ff @(posedge clk or posedge reset_N) begin
		if (reset_N)
			state <= idle_st;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			idle_st:    if (start) next_state = fetch_st;       // start ignored elsewhere
			fetch_st:   next_state = score_st;
			score_st:   if (iou_valid) next_state = compare_st;
			compare_st: next_state = slot_last ? finish_st : fetch_st;
			finish_st:  next_state = idle_st;
			default:    next_state = idle_st;
		endcase
	end

	// ----------------------------------------
	// strobes
	// ----------------------------------------
	assign cnt_clr   = (state == idle_st) && start;   // slot 0 for the first fetch
	assign sel_clr   = (state == idle_st) && start;   // drop last run's minimum
	assign iou_start = (state == fetch_st);
	assign sel_load  = (state == score_st) && iou_valid;
	assign cnt_step  = (state == compare_st) && !slot_last;
	assign busy      = (state != idle_st);
	assign done      = (state == finish_st);          // selector already settled here

	// iou answers only to a request issued from fetch
	a_valid_in_score: assert property (@(posedge clk) disable iff (reset_N)
		iou_valid |-> (state == score_st));

endmodule

// File: oflow_best_select.sv
`include "oflow_cfg.svh"

module oflow_best_select (
	input  logic                  clk,
	input  logic                  reset_N,
	input  logic                  clr,
	input  logic                  load,
	input  oflow_bbox_pkg::cost_t cost,
	input  oflow_bbox_pkg::slot_t idx,
	output oflow_bbox_pkg::cost_t best_cost,
	output oflow_bbox_pkg::slot_t best_idx,
	output logic                  no_match
);

	// ----------------------------------------
	// running minimum
	// ----------------------------------------
	always_ff @(posedge clk or posedge reset_N) begin
		if (reset_N) begin
			best_cost <= '1;   // worst possible cost
			best_idx  <= '0;
		end else if (clr) begin
			best_cost <= '1;
			best_idx  <= '0;
		end else if (load && (cost < best_cost)) begin
			// strict compare, a tie keeps the earlier slot
			best_cost <= cost;
			best_idx  <= idx;
		end
	end

	// reject when even the best is too far off
	assign no_match = (best_cost > `NO_MATCH_THR);

endmodule

// File: oflow_match.sv
module oflow_match (
	input  logic                   clk,
	input  logic                   reset_N,
	input  logic                   start,
	input  logic                   hist_we,
	input  oflow_bbox_pkg::slot_t  hist_addr,
	input  oflow_bbox_pkg::coord_t hist_x_tl,
	input  oflow_bbox_pkg::coord_t hist_y_tl,
	input  oflow_bbox_pkg::coord_t hist_x_br,
	input  oflow_bbox_pkg::coord_t hist_y_br,
	input  oflow_bbox_pkg::coord_t cur_x_tl,
	input  oflow_bbox_pkg::coord_t cur_y_tl,
	input  oflow_bbox_pkg::coord_t cur_x_br,
	input  oflow_bbox_pkg::coord_t cur_y_br,
	output logic                   done,
	output logic                   busy,
	output oflow_bbox_pkg::slot_t  best_idx,
	output oflow_bbox_pkg::cost_t  best_cost,
	output logic                   no_match
);
	import oflow_bbox_pkg::*;

	slot_t  slot_idx;     // slot under evaluation
	logic   slot_last;
	logic   cnt_clr;
	logic   cnt_step;
	logic   iou_start;
	logic   iou_valid;
	cost_t  iou_cost;
	logic   sel_clr;
	logic   sel_load;
	coord_t h_x_tl;       // history box at slot_idx
	coord_t h_y_tl;
	coord_t h_x_br;
	coord_t h_y_br;

	// ----------------------------------------
	// storage and slot walk
	// ----------------------------------------
	oflow_history_buf hist_i (
		.clk     (clk),       .reset_N (reset_N),
		.we      (hist_we),   .waddr   (hist_addr),
		.w_x_tl  (hist_x_tl), .w_y_tl  (hist_y_tl),
		.w_x_br  (hist_x_br), .w_y_br  (hist_y_br),
		.raddr   (slot_idx),
		.r_x_tl  (h_x_tl),    .r_y_tl  (h_y_tl),
		.r_x_br  (h_x_br),    .r_y_br  (h_y_br)
	);

	oflow_slot_counter cnt_i (
		.clk       (clk),     .reset_N   (reset_N),
		.clr       (cnt_clr), .step      (cnt_step),
		.slot_idx  (slot_idx),
		.slot_last (slot_last)
	);

	oflow_match_fsm fsm_i (
		.clk       (clk),       .reset_N   (reset_N),
		.start     (start),     .iou_valid (iou_valid),
		.slot_last (slot_last), .iou_start (iou_start),
		.cnt_clr   (cnt_clr),   .cnt_step  (cnt_step),
		.sel_clr   (sel_clr),   .sel_load  (sel_load),
		.done      (done),      .busy      (busy)
	);

	// ----------------------------------------
	// scoring and selection
	// ----------------------------------------
	oflow_calc_iou iou_i (
		.clk       (clk),      .reset_N  (reset_N),
		.start     (iou_start),
		.a_x_tl    (cur_x_tl), .a_y_tl   (cur_y_tl),
		.a_x_br    (cur_x_br), .a_y_br   (cur_y_br),
		.b_x_tl    (h_x_tl),   .b_y_tl   (h_y_tl),
		.b_x_br    (h_x_br),   .b_y_br   (h_y_br),
		.valid_iou (iou_valid),
		.iou_cost  (iou_cost)
	);

	oflow_best_select sel_i (
		.clk       (clk),      .reset_N  (reset_N),
		.clr       (sel_clr),  .load     (sel_load),
		.cost      (iou_cost), .idx      (slot_idx),
		.best_cost (best_cost),
		.best_idx  (best_idx),
		.no_match  (no_match)
	);

endmodule

// File: oflow_match_tb.sv
`include "oflow_cfg.svh"

module oflow_match_tb;
	import oflow_bbox_pkg::*;
	import oflow_ctrl_pkg::*;

	localparam int RUN_CYC  = `HIST_DEPTH * 22 + 2;  // start to done
	localparam int DONE_TMO = 4 * RUN_CYC;
	localparam int N_RAND   = 12;
	localparam logic [31:0] SEED = 32'h5355_46c1;

	logic   clk;
	logic   reset_N;
	logic   start;
	logic   hist_we;
	slot_t  hist_addr;
	coord_t hist_x_tl;
	coord_t hist_y_tl;
	coord_t hist_x_br;
	coord_t hist_y_br;
	coord_t cur_x_tl;
	coord_t cur_y_tl;
	coord_t cur_x_br;
	coord_t cur_y_br;
	logic   done;
	logic   busy;
	slot_t  best_idx;
	cost_t  best_cost;
	logic   no_match;

	// stimulus table, boxes packed as {x_tl, y_tl, x_br, y_br}
	string       t_name[$];
	logic [3:0]  t_mask[$];     // slots rewritten before the run
	bit          t_extra[$];    // second start while busy
	logic [39:0] t_hist[$];     // four entries per row
	logic [39:0] t_cur[$];
	int          t_exp_idx[$];  // -1 leaves it to the model
	int          t_exp_nm[$];

	logic [39:0] shadow [`HIST_DEPTH];  // host copy of the history table

	oflow_match dut_i (
		.clk       (clk),       .reset_N   (reset_N),
		.start     (start),     .hist_we   (hist_we),
		.hist_addr (hist_addr),
		.hist_x_tl (hist_x_tl), .hist_y_tl (hist_y_tl),
		.hist_x_br (hist_x_br), .hist_y_br (hist_y_br),
		.cur_x_tl  (cur_x_tl),  .cur_y_tl  (cur_y_tl),
		.cur_x_br  (cur_x_br),  .cur_y_br  (cur_y_br),
		.done      (done),      .busy      (busy),
		.best_idx  (best_idx),  .best_cost (best_cost),
		.no_match  (no_match)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;  // period 10
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [39:0] box(input int x0, input int y0, input int x1, input int y1);
		return {coord_t'(x0), coord_t'(y0), coord_t'(x1), coord_t'(y1)};
	endfunction

	function automatic logic [39:0] rand_box();
		int x0;
		int y0;
		x0 = $urandom_range(0, 150);
		y0 = $urandom_range(0, 150);
		return box(x0, y0, x0 + $urandom_range(0, 60), y0 + $urandom_range(0, 60));  // ordered
	endfunction

	function automatic int side(input int tl, input int br);
		return (br > tl) ? br - tl : 0;
	endfunction

	// 1 - inter/union in q0.16, straight from the cost rule
	function automatic cost_t ref_cost(input logic [39:0] a, input logic [39:0] b);
		int     ix0;
		int     iy0;
		int     ix1;
		int     iy1;
		longint inter;
		longint area_a;
		longint area_b;
		longint uni;
		longint q;
		longint full;
		full   = (longint'(1) << `FRAC_W) - 1;
		ix0    = (a[39:30] > b[39:30]) ? a[39:30] : b[39:30];  // larger top-left
		iy0    = (a[29:20] > b[29:20]) ? a[29:20] : b[29:20];
		ix1    = (a[19:10] < b[19:10]) ? a[19:10] : b[19:10];  // smaller bottom-right
		iy1    = (a[9:0] < b[9:0]) ? a[9:0] : b[9:0];
		inter  = longint'(side(ix0, ix1)) * side(iy0, iy1);
		area_a = longint'(side(a[39:30], a[19:10])) * side(a[29:20], a[9:0]);
		area_b = longint'(side(b[39:30], b[19:10])) * side(b[29:20], b[9:0]);
		uni    = area_a + area_b - inter;
		if (uni == 0)
			return '1;
		q = (inter << `FRAC_W) / uni;
		if (q >= full)
			return '0;  // saturate
		return cost_t'(full - q);
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check(input string test, input string what,
	                     input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAILED %s %s expected %0h actual %0h", test, what, exp, act);
			fail_run("mismatch against expected value");
		end
	endtask

	task automatic add_row(input string name, input logic [3:0] mask, input bit extra,
	                       input logic [39:0] h0, input logic [39:0] h1,
	                       input logic [39:0] h2, input logic [39:0] h3,
	                       input logic [39:0] cur, input int e_idx, input int e_nm);
		t_name.push_back(name);
		t_mask.push_back(mask);
		t_extra.push_back(extra);
		t_hist.push_back(h0);
		t_hist.push_back(h1);
		t_hist.push_back(h2);
		t_hist.push_back(h3);
		t_cur.push_back(cur);
		t_exp_idx.push_back(e_idx);
		t_exp_nm.push_back(e_nm);
	endtask

	task automatic pulse_start();
		@(posedge clk);
		#1 start = 1'b1;
		@(posedge clk);
		#1 start = 1'b0;
	endtask

	task automatic wait_done(input string test);
		int           n;
		match_state_t st;
		for (n = 0; n < DONE_TMO && !done; n++) begin
			@(posedge clk);
			#1;
		end
		if (!done) begin
			st = match_state_t'(dut_i.fsm_i.state);
			fail_run($sformatf("%s: no done within %0d cycles, controller stuck in %s",
			                   test, DONE_TMO, st.name()));
		end
	endtask

	// ----------------------------------------
	// one table row end to end
	// ----------------------------------------
	task automatic run_row(input int r);
		int    s;
		cost_t c;
		cost_t exp_cost;
		int    exp_idx;
		for (s = 0; s < `HIST_DEPTH; s++) begin
			if (t_mask[r][s]) begin
				@(posedge clk);
				#1 hist_we = 1'b1;
				hist_addr = slot_t'(s);
				{hist_x_tl, hist_y_tl, hist_x_br, hist_y_br} = t_hist[r*4+s];
				shadow[s] = t_hist[r*4+s];
			end
		end
		@(posedge clk);
		#1 hist_we = 1'b0;
		{cur_x_tl, cur_y_tl, cur_x_br, cur_y_br} = t_cur[r];  // held through the run

		pulse_start();
		if (t_extra[r]) begin
			repeat (5) @(posedge clk);
			#1;
			check(t_name[r], "busy", 1, busy);
			start = 1'b1;  // should be ignored
			@(posedge clk);
			#1 start = 1'b0;
		end
		wait_done(t_name[r]);

		// model: strict minimum keeps the lower slot on a tie
		exp_cost = '1;
		exp_idx  = 0;
		for (s = 0; s < `HIST_DEPTH; s++) begin
			c = ref_cost(t_cur[r], shadow[s]);
			if (c < exp_cost) begin
				exp_cost = c;
				exp_idx  = s;
			end
		end
		check(t_name[r], "best_cost", exp_cost, best_cost);
		check(t_name[r], "best_idx", exp_idx, best_idx);
		check(t_name[r], "no_match", (exp_cost > `NO_MATCH_THR), no_match);
		if (t_exp_idx[r] >= 0)
			check(t_name[r], "table best_idx", t_exp_idx[r], best_idx);
		if (t_exp_nm[r] >= 0)
			check(t_name[r], "table no_match", t_exp_nm[r], no_match);

		if (t_extra[r]) begin
			for (s = 0; s < RUN_CYC; s++) begin  // nothing more may follow
				@(posedge clk);
				#1;
				if (done)
					fail_run($sformatf("%s: second done after a start issued while busy",
					                   t_name[r]));
			end
			check(t_name[r], "busy after run", 0, busy);
		end
	endtask

	// ----------------------------------------
	// table
	// ----------------------------------------
	task automatic build_table();
		int          r;
		logic [39:0] h [4];
		logic [39:0] cur;
		add_row("identical_slot2", 4'b1111, 0, box(0, 0, 10, 10), box(100, 100, 120, 120),
		        box(50, 60, 90, 100), box(200, 200, 210, 210), box(50, 60, 90, 100), 2, 0);
		add_row("partial_best", 4'b1111, 0, box(0, 0, 20, 20), box(5, 0, 25, 20),
		        box(10, 0, 30, 20), box(300, 300, 310, 310), box(2, 0, 22, 20), 0, 0);
		add_row("tie_lower_idx", 4'b1111, 0, box(15, 0, 35, 20), box(0, 0, 20, 20),
		        box(10, 0, 30, 20), box(500, 500, 510, 510), box(5, 0, 25, 20), 1, 0);
		add_row("disjoint_all", 4'b1111, 0, box(0, 0, 20, 20), box(30, 30, 60, 60),
		        box(10, 70, 40, 90), box(80, 0, 99, 50), box(600, 600, 650, 650), 0, 1);
		add_row("zero_area", 4'b1111, 0, box(40, 40, 30, 30), box(40, 40, 40, 60),
		        box(0, 0, 50, 50), box(45, 45, 45, 45), box(40, 40, 40, 40), 0, 1);
		add_row("weak_overlap", 4'b1111, 0, box(9, 9, 19, 19), box(300, 0, 310, 10),
		        box(0, 300, 10, 310), box(400, 400, 420, 420), box(0, 0, 10, 10), 0, 1);
		// single-slot rewrites on top of the previous row
		add_row("overwrite_slot3_hit", 4'b1000, 1, '0, '0, '0,
		        box(0, 0, 10, 10), box(0, 0, 10, 10), 3, 0);
		add_row("overwrite_slot3_away", 4'b1000, 0, '0, '0, '0,
		        box(700, 700, 710, 710), box(0, 0, 10, 10), 0, 1);

		for (r = 0; r < N_RAND; r++) begin
			h[0] = rand_box();
			h[1] = rand_box();
			h[2] = rand_box();
			h[3] = rand_box();
			cur  = (r % 3 == 0) ? h[r % 4] : rand_box();  // some exact hits
			add_row($sformatf("random_%0d", r), 4'b1111, 0, h[0], h[1], h[2], h[3], cur, -1, -1);
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int r;
		void'($urandom(SEED));  // fixed seed, repeatable random rows
		reset_N   = 1'b1;
		start     = 1'b0;
		hist_we   = 1'b0;
		hist_addr = '0;
		{hist_x_tl, hist_y_tl, hist_x_br, hist_y_br} = '0;
		{cur_x_tl, cur_y_tl, cur_x_br, cur_y_br} = '0;
		for (r = 0; r < `HIST_DEPTH; r++)
			shadow[r] = '0;  // table clears on reset
		build_table();

		repeat (10) @(posedge clk);
		#1 reset_N = 1'b0;

		check("reset", "done", 0, done);
		check("reset", "busy", 0, busy);
		check("reset", "best_cost", 16'hFFFF, best_cost);
		check("reset", "best_idx", 0, best_idx);

		for (r = 0; r < t_name.size(); r++)
			run_row(r);

		$display("** PASS **");
		$finish;
	end

endmodule

// File: oflow_match.f
+incdir+.
oflow_bbox_pkg.sv
oflow_ctrl_pkg.sv
oflow_history_buf.sv
oflow_seq_div.sv
oflow_calc_iou.sv
oflow_slot_counter.sv
oflow_match_fsm.sv
oflow_best_select.sv
oflow_match.sv
oflow_match_tb.sv
